//--- hw/bus_pkg.sv
package bus_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// register page and offsets inside it
	localparam logic [7:0] IO_PAGE = 8'hff;
	localparam logic [7:0] SB_OFS  = 8'h01; // transfer data
	localparam logic [7:0] SC_OFS  = 8'h02; // transfer control

	localparam logic [ADDR_W-1:0] REG_SB = {IO_PAGE, SB_OFS};
	localparam logic [ADDR_W-1:0] REG_SC = {IO_PAGE, SC_OFS};

	// value returned for any address outside the port
	localparam logic [DATA_W-1:0] OPEN_BUS = 8'hff;

	typedef enum logic {
		op_read,
		op_write
	} bus_op_e;

endpackage

//--- hw/link_pkg.sv
package link_pkg;

	// transfer sequencing of the shift engine
	typedef enum logic [1:0] {
		st_idle,
		st_shift,
		st_done
	} xfer_state_e;

	// bit positions inside SC
	localparam int SC_START  = 7; // transfer start / busy
	localparam int SC_CLKSEL = 0; // 1 = internal clock

	localparam int BITS_PER_XFER = 8; // one byte per transfer

endpackage

//--- hw/cpu_bus_port.sv
`timescale 1ns/1ps

module cpu_bus_port (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       bus_req,
	input  bus_pkg::bus_op_e           bus_op,
	input  logic [bus_pkg::ADDR_W-1:0] bus_addr,
	input  logic [bus_pkg::DATA_W-1:0] bus_wdata,
	output logic                       bus_ack,
	output logic [7:0]                 bus_rdata,
	input  logic [7:0]                 sb_q,
	input  logic                       start_q,
	input  logic                       clksel_q,
	output logic                       sb_wr,
	output logic                       sc_wr,
	output logic [7:0]                 wdata
);
	import bus_pkg::*;
	import link_pkg::*;

	typedef enum logic [1:0] {
		bp_idle,
		bp_access,
		bp_ack
	} bp_state_e;

	bp_state_e  state;
	logic       hit_sb;
	logic       hit_sc;
	logic [7:0] sc_rd;
	logic [7:0] rd_mux;

	assign hit_sb = bus_addr == REG_SB;
	assign hit_sc = bus_addr == REG_SC;

	always_comb begin
		sc_rd             = 8'hff; // unused bits read high
		sc_rd[SC_START]  = start_q;
		sc_rd[SC_CLKSEL] = clksel_q;
	end

	always_comb begin
		if (hit_sb)
			rd_mux = sb_q;
		else if (hit_sc)
			rd_mux = sc_rd;
		else
			rd_mux = OPEN_BUS;
	end

	assign bus_ack = state == bp_ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= bp_idle;
			sb_wr <= 1'b0;
			sc_wr <= 1'b0;
		end else begin
			sb_wr <= 1'b0; // strobes last one cycle
			sc_wr <= 1'b0;
			case (state)
				bp_idle: begin
					if (bus_req) begin
						state <= bp_access;
						sb_wr <= (bus_op == op_write) && hit_sb;
						sc_wr <= (bus_op == op_write) && hit_sc;
					end
				end
				bp_access: state <= bp_ack; // read value captured here
				bp_ack: begin
					if (!bus_req)
						state <= bp_idle;
				end
				default: state <= bp_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == bp_idle && bus_req)
			wdata <= bus_wdata;
		if (state == bp_access)
			bus_rdata <= rd_mux; // held through the ack phase
	end

endmodule

//--- hw/serial_clock_gen.sv
`timescale 1ns/1ps

module serial_clock_gen #(
	parameter int DIV_RATIO = 16
) (
	input  logic clk,
	input  logic rst,
	input  logic run,
	input  logic clksel_q,
	input  logic sck_in,
	output logic shift_tick,
	output logic sck_out,
	output logic sck_dir
);
	localparam int CNT_W = (DIV_RATIO > 1) ? $clog2(DIV_RATIO) : 1;

	logic [CNT_W-1:0] div_cnt;
	logic             int_run;
	logic             int_tick;
	logic             ext_tick;
	logic             sck_meta;
	logic             sck_sync;
	logic             sck_prev;

	assign int_run  = run && clksel_q;
	assign int_tick = int_run && (div_cnt == CNT_W'(DIV_RATIO - 1)); // end of bit period

	always_ff @(posedge clk) begin
		if (rst)
			div_cnt <= '0;
		else if (!int_run || int_tick)
			div_cnt <= '0; // restart at each bit boundary
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// external clock pin crosses into clk here
	always_ff @(posedge clk) begin
		if (rst) begin
			sck_meta <= 1'b0;
			sck_sync <= 1'b0;
			sck_prev <= 1'b0;
		end else begin
			sck_meta <= sck_in;
			sck_sync <= sck_meta;
			sck_prev <= sck_sync;
		end
	end

	assign ext_tick   = run && !clksel_q && sck_sync && !sck_prev; // rising edge
	assign shift_tick = int_tick || ext_tick;
	assign sck_out    = !(int_run && (div_cnt < CNT_W'(DIV_RATIO / 2))); // low first half
	assign sck_dir    = clksel_q; // drive the pin only as master

endmodule

//--- hw/shift_engine.sv
`timescale 1ns/1ps

module shift_engine (
	input  logic       clk,
	input  logic       rst,
	input  logic       sb_wr,
	input  logic       sc_wr,
	input  logic [7:0] wdata,
	input  logic       shift_tick,
	input  logic       sin_in,
	output logic [7:0] sb_q,
	output logic       start_q,
	output logic       clksel_q,
	output logic       run,
	output logic       ser_out,
	output logic       xfer_done
);
	import link_pkg::*;

	localparam int CNT_W = $clog2(BITS_PER_XFER);

	xfer_state_e      state;
	logic [CNT_W-1:0] bit_cnt;
	logic             last_bit;
	logic             go;

	assign go       = sc_wr && wdata[SC_START];
	assign last_bit = bit_cnt == CNT_W'(BITS_PER_XFER - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= st_idle;
			bit_cnt <= '0;
		end else begin
			case (state)
				st_idle, st_done: begin
					if (go) begin
						state   <= st_shift;
						bit_cnt <= '0;
					end else begin
						state <= st_idle; // st_done lasts one cycle
					end
				end
				st_shift: begin
					if (sc_wr && !wdata[SC_START]) begin
						state <= st_idle; // start bit cleared by cpu aborts
					end else if (shift_tick) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit)
							state <= st_done;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sb_q     <= 8'h00;
			clksel_q <= 1'b0;
		end else begin
			if (sc_wr)
				clksel_q <= wdata[SC_CLKSEL];
			if (state == st_shift) begin
				if (shift_tick)
					sb_q <= {sb_q[6:0], sin_in}; // msb out, new bit in at lsb
			end else if (sb_wr) begin
				sb_q <= wdata; // cpu writes dropped while shifting
			end
		end
	end

	assign run       = state == st_shift;
	assign start_q   = state == st_shift; // busy flag seen in SC
	assign xfer_done = state == st_done;
	assign ser_out   = run ? sb_q[7] : 1'b1; // line idles high

endmodule

//--- hw/irq_handshake.sv
`timescale 1ns/1ps

module irq_handshake (
	input  logic clk,
	input  logic rst,
	input  logic xfer_done,
	input  logic irq_ack,
	output logic int_serial
);
	typedef enum logic [1:0] {
		irq_idle,
		irq_req,
		irq_wait_low
	} irq_state_e;

	irq_state_e state;
	logic       pending;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= irq_idle;
			pending <= 1'b0;
		end else begin
			case (state)
				irq_idle: begin
					if (xfer_done || pending) begin
						state   <= irq_req;
						pending <= 1'b0;
					end
				end
				irq_req: begin
					if (xfer_done)
						pending <= 1'b1; // further dones merge here
					if (irq_ack)
						state <= irq_wait_low;
				end
				irq_wait_low: begin
					if (xfer_done)
						pending <= 1'b1;
					if (!irq_ack)
						state <= irq_idle; // handshake closed
				end
				default: state <= irq_idle;
			endcase
		end
	end

	assign int_serial = state == irq_req;

endmodule

//--- hw/serial_link_top.sv
`timescale 1ns/1ps

module serial_link_top #(
	parameter int DIV_RATIO = 16
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       bus_req,
	input  bus_pkg::bus_op_e           bus_op,
	input  logic [bus_pkg::ADDR_W-1:0] bus_addr,
	input  logic [bus_pkg::DATA_W-1:0] bus_wdata,
	output logic                       bus_ack,
	output logic [7:0]                 bus_rdata,
	input  logic                       sin_in,
	input  logic                       sck_in,
	output logic                       ser_out,
	output logic                       sck_out,
	output logic                       sck_dir,
	input  logic                       irq_ack,
	output logic                       int_serial
);
	logic       sb_wr;
	logic       sc_wr;
	logic [7:0] wdata;
	logic [7:0] sb_q;
	logic       start_q;
	logic       clksel_q;
	logic       run;
	logic       shift_tick;
	logic       xfer_done;

	cpu_bus_port i_cpu_bus_port (
		.clk       (clk),
		.rst       (rst),
		.bus_req   (bus_req),
		.bus_op    (bus_op),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_ack   (bus_ack),
		.bus_rdata (bus_rdata),
		.sb_q      (sb_q),
		.start_q   (start_q),
		.clksel_q  (clksel_q),
		.sb_wr     (sb_wr),
		.sc_wr     (sc_wr),
		.wdata     (wdata)
	);

	serial_clock_gen #(
		.DIV_RATIO (DIV_RATIO)
	) i_serial_clock_gen (
		.clk        (clk),
		.rst        (rst),
		.run        (run),
		.clksel_q   (clksel_q),
		.sck_in     (sck_in),
		.shift_tick (shift_tick),
		.sck_out    (sck_out),
		.sck_dir    (sck_dir)
	);

	shift_engine i_shift_engine (
		.clk        (clk),
		.rst        (rst),
		.sb_wr      (sb_wr),
		.sc_wr      (sc_wr),
		.wdata      (wdata),
		.shift_tick (shift_tick),
		.sin_in     (sin_in),
		.sb_q       (sb_q),
		.start_q    (start_q),
		.clksel_q   (clksel_q),
		.run        (run),
		.ser_out    (ser_out),
		.xfer_done  (xfer_done)
	);

	irq_handshake i_irq_handshake (
		.clk        (clk),
		.rst        (rst),
		.xfer_done  (xfer_done),
		.irq_ack    (irq_ack),
		.int_serial (int_serial)
	);

endmodule

//--- testbench/tb_serial_link.sv
`timescale 1ns/1ps

module tb_serial_link;
	import bus_pkg::*;
	import link_pkg::*;

	localparam int DIV_RATIO = 16;
	localparam int MAX_ROWS  = 16;
	localparam int EXT_HALF  = 40; // clk cycles per sck_in edge

	typedef enum int {
		act_write,
		act_read,
		act_int,
		act_ext,
		act_double
	} act_e;

	logic       clk       = 1'b0;
	logic       rst       = 1'b1;
	logic       bus_req   = 1'b0;
	bus_op_e    bus_op    = op_read;
	logic [15:0] bus_addr = 16'h0000;
	logic [7:0] bus_wdata = 8'h00;
	logic       sin_in    = 1'b1;
	logic       sck_in    = 1'b1;
	logic       irq_ack   = 1'b0;
	logic       bus_ack;
	logic [7:0] bus_rdata;
	logic       ser_out;
	logic       sck_out;
	logic       sck_dir;
	logic       int_serial;

	string      row_name [MAX_ROWS];
	act_e       row_act  [MAX_ROWS];
	logic [15:0] row_addr [MAX_ROWS];
	logic [7:0] row_data [MAX_ROWS];
	logic [7:0] row_exp  [MAX_ROWS];
	int         n_rows     = 0;
	int         budget     = 0;
	logic       rows_ready = 1'b0;
	logic [7:0] rnd [5];
	integer     seed       = 48;
	int         cyc        = 0;
	int         req_cyc    = 0; // cycle in which the last bus_req was seen
	int         errors     = 0;
	int         pass_cnt   = 0;
	int         fail_cnt   = 0;

	serial_link_top #(
		.DIV_RATIO (DIV_RATIO)
	) i_serial_link_top (
		.clk        (clk),
		.rst        (rst),
		.bus_req    (bus_req),
		.bus_op     (bus_op),
		.bus_addr   (bus_addr),
		.bus_wdata  (bus_wdata),
		.bus_ack    (bus_ack),
		.bus_rdata  (bus_rdata),
		.sin_in     (sin_in),
		.sck_in     (sck_in),
		.ser_out    (ser_out),
		.sck_out    (sck_out),
		.sck_dir    (sck_dir),
		.irq_ack    (irq_ack),
		.int_serial (int_serial)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic step(); // drive point 2 ns after the edge
		@(posedge clk);
		#2;
	endtask

	task automatic check_value(input string name, input logic [31:0] expv,
			input logic [31:0] actv);
		if (actv !== expv) begin
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, expv, actv);
			errors++;
		end
	endtask

	task automatic add_row(input string name, input act_e act, input logic [15:0] addr,
			input logic [7:0] data, input logic [7:0] expv);
		row_name[n_rows] = name;
		row_act[n_rows]  = act;
		row_addr[n_rows] = addr;
		row_data[n_rows] = data;
		row_exp[n_rows]  = expv;
		n_rows++;
	endtask

	function automatic int worst_cycles(input act_e act);
		case (act)
			act_int:    return BITS_PER_XFER * DIV_RATIO + 100;
			act_ext:    return 2 * BITS_PER_XFER * EXT_HALF + 100;
			act_double: return 2 * (BITS_PER_XFER * DIV_RATIO + 100) + 60;
			default:    return 20;
		endcase
	endfunction

	// four-phase bus access, returns the read data
	task automatic bus_access(input string name, input bus_op_e op, input logic [15:0] addr,
			input logic [7:0] data, output logic [7:0] rdata);
		int n;
		bus_op    = op;
		bus_addr  = addr;
		bus_wdata = data;
		bus_req   = 1'b1;
		step();
		req_cyc = cyc;
		n = 0;
		while (!bus_ack && n < 10) begin
			step();
			n++;
		end
		if (!bus_ack) begin
			$display("%s: bus_ack never rose for address %h", name, addr);
			errors++;
		end
		rdata   = bus_rdata;
		bus_req = 1'b0;
		n = 0;
		while (bus_ack && n < 10) begin
			step();
			n++;
		end
		if (bus_ack) begin
			$display("%s: bus_ack did not fall after bus_req was released", name);
			errors++;
		end
	endtask

	// serial partner, msb first, also collects ser_out
	task automatic partner(input string name, input logic internal, input logic [7:0] pbyte,
			output logic [7:0] got);
		for (int i = BITS_PER_XFER - 1; i >= 0; i--) begin
			if (internal) begin
				@(posedge sck_out);
				#2;
				check_value(name, 1, sck_dir); // master drives the clock
				// low half of the bit first, rise in the middle
				check_value(name, (BITS_PER_XFER - 1 - i) * DIV_RATIO + DIV_RATIO / 2 + 1,
					cyc - req_cyc);
			end else begin
				repeat (EXT_HALF) step();
				sck_in = 1'b0;
			end
			sin_in = pbyte[i];
			got[i] = ser_out;
			if (!internal) begin
				check_value(name, 0, sck_dir); // pin stays an input
				check_value(name, 0, int_serial); // no request before the last edge
				repeat (EXT_HALF) step();
				sck_in = 1'b1;
			end
		end
	endtask

	task automatic answer_irq(input string name);
		int n;
		repeat (5) begin
			step();
			check_value(name, 1, int_serial); // held until acked
		end
		irq_ack = 1'b1;
		n = 0;
		while (int_serial && n < 10) begin
			step();
			n++;
		end
		check_value(name, 0, int_serial);
		irq_ack = 1'b0;
		step();
		step();
	endtask

	task automatic run_xfer(input string name, input logic internal, input logic [7:0] pbyte,
			input logic [7:0] exp_out, input logic answer);
		logic [7:0] got;
		logic [7:0] rd_sc;
		logic [7:0] rd_sb;
		logic       was_low;
		int         n;
		was_low = !int_serial;
		fork
			bus_access(name, op_write, REG_SC, internal ? 8'h81 : 8'h80, rd_sc);
			partner(name, internal, pbyte, got);
			if (!internal) begin
				repeat (100) step();
				bus_access(name, op_write, REG_SB, ~exp_out, rd_sb); // must be dropped
			end
		join
		if (was_low) begin
			n = 0;
			while (!int_serial && n < 40) begin
				step();
				n++;
			end
			if (!int_serial) begin
				$display("%s: int_serial did not rise after the transfer", name);
				errors++;
			end else if (internal) begin
				check_value(name, BITS_PER_XFER * DIV_RATIO + 2, cyc - req_cyc);
			end
		end
		n = 0;
		do begin
			bus_access(name, op_read, REG_SC, 8'h00, rd_sc);
			n++;
		end while (rd_sc[7] && n < 20);
		check_value(name, internal ? 8'h7f : 8'h7e, rd_sc);
		bus_access(name, op_read, REG_SB, 8'h00, rd_sb);
		check_value(name, pbyte, rd_sb);
		check_value(name, exp_out, got);
		if (answer)
			answer_irq(name);
	endtask

	// two transfers without ack give one extra request
	task automatic merge_irq(input string name, input logic [7:0] pbyte, input logic [7:0] exp_out);
		int n;
		run_xfer(name, 1'b1, pbyte, exp_out, 1'b0);
		run_xfer(name, 1'b1, ~pbyte, pbyte, 1'b0);
		answer_irq(name);
		n = 0;
		while (!int_serial && n < 10) begin
			step();
			n++;
		end
		check_value(name, 1, int_serial); // pending request raised
		answer_irq(name);
		repeat (20) begin
			step();
			check_value(name, 0, int_serial);
		end
	endtask

	initial begin
		wait (rows_ready);
		repeat ((budget + 8) * 3 / 2) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", (budget + 8) * 3 / 2);
		$display("Regression failed");
		$finish;
	end

	initial begin
		logic [7:0] rd;
		int         err_before;
		for (int i = 0; i < 5; i++)
			rnd[i] = $random(seed);
		add_row("reset_sb", act_read, REG_SB, 8'h00, 8'h00);
		add_row("reset_sc", act_read, REG_SC, 8'h00, 8'h7e);
		add_row("unmapped_rd", act_read, 16'hff03, 8'h00, 8'hff);
		add_row("sb_write", act_write, REG_SB, rnd[0], 8'h00);
		add_row("sb_readback", act_read, REG_SB, 8'h00, rnd[0]);
		add_row("int_xfer", act_int, REG_SC, rnd[1], rnd[0]);
		add_row("ext_xfer", act_ext, REG_SC, rnd[2], rnd[1]);
		add_row("sb_write2", act_write, REG_SB, rnd[3], 8'h00);
		add_row("irq_merge", act_double, REG_SC, rnd[4], rnd[3]);
		add_row("unmapped_wr", act_write, 16'hff40, 8'h5a, 8'h00);
		add_row("sb_after", act_read, REG_SB, 8'h00, ~rnd[4]);
		for (int r = 0; r < n_rows; r++)
			budget += worst_cycles(row_act[r]);
		rows_ready = 1'b1;

		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		step();
		err_before = errors;
		check_value("reset_pins", 0, bus_ack);
		check_value("reset_pins", 0, int_serial);
		check_value("reset_pins", 0, sck_dir);
		check_value("reset_pins", 1, ser_out); // line idles high
		check_value("reset_pins", 1, sck_out);
		if (errors == err_before) begin
			pass_cnt++;
			$display("test reset_pins: pass");
		end else begin
			fail_cnt++;
			$display("test reset_pins: fail");
		end

		for (int r = 0; r < n_rows; r++) begin
			err_before = errors;
			case (row_act[r])
				act_write: bus_access(row_name[r], op_write, row_addr[r], row_data[r], rd);
				act_read: begin
					bus_access(row_name[r], op_read, row_addr[r], 8'h00, rd);
					check_value(row_name[r], row_exp[r], rd);
				end
				act_int: run_xfer(row_name[r], 1'b1, row_data[r], row_exp[r], 1'b1);
				act_ext: run_xfer(row_name[r], 1'b0, row_data[r], row_exp[r], 1'b1);
				default: merge_irq(row_name[r], row_data[r], row_exp[r]);
			endcase
			if (errors == err_before) begin
				pass_cnt++;
				$display("test %s: pass", row_name[r]);
			end else begin
				fail_cnt++;
				$display("test %s: fail", row_name[r]);
			end
		end

		$display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- tb.f
hw/bus_pkg.sv
hw/link_pkg.sv
hw/cpu_bus_port.sv
hw/serial_clock_gen.sv
hw/shift_engine.sv
hw/irq_handshake.sv
hw/serial_link_top.sv
testbench/tb_serial_link.sv

//--- Bender.yml
package:
  name: serial_link

sources:
  - files:
      - hw/bus_pkg.sv
      - hw/link_pkg.sv
      - hw/cpu_bus_port.sv
      - hw/serial_clock_gen.sv
      - hw/shift_engine.sv
      - hw/irq_handshake.sv
      - hw/serial_link_top.sv
  - target: test
    files:
      - testbench/tb_serial_link.sv
